// ==== hist_pkg.sv ====
package hist_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        reset_all   = 2'b00,
        input_count = 2'b01,
        pixel_count = 2'b10,
        acq_count   = 2'b11
    } seq_state_t;

    // per-cycle event code
    typedef enum logic [1:0] {
        ev_idle   = 2'b00,
        ev_fine   = 2'b01, // bin on low time bits
        ev_resv   = 2'b10, // ignored
        ev_coarse = 2'b11  // bin on high time bits
    } ev_op_t;

endpackage

// ==== hist_sequencer.sv ====
`timescale 1ns/1ps

module hist_sequencer #(
    parameter int INPUTS_PER_PIXEL = 2,
    parameter int PIXELS_PER_ACQ   = 200,
    parameter int ACQ_PER_HIST     = 33333
) (
    input  logic clk,
    input  logic res,
    output logic window,
    output logic acq_done,
    output logic his_num
);

    localparam int IN_W  = $clog2(INPUTS_PER_PIXEL + 1);
    localparam int PIX_W = $clog2(PIXELS_PER_ACQ + 1);
    localparam int ACQ_W = $clog2(ACQ_PER_HIST + 1);

    hist_pkg::seq_state_t state, state_nxt;

    logic [IN_W-1:0]  in_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic in_last, pix_last, acq_last;

    assign in_last  = (in_cnt == IN_W'(INPUTS_PER_PIXEL - 1));
    assign pix_last = (pix_cnt == PIX_W'(PIXELS_PER_ACQ - 1));
    assign acq_last = (acq_cnt == ACQ_W'(ACQ_PER_HIST - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= hist_pkg::reset_all;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            hist_pkg::reset_all:
                state_nxt = hist_pkg::input_count;
            hist_pkg::input_count:
                state_nxt = in_last ? hist_pkg::pixel_count : hist_pkg::input_count;
            hist_pkg::pixel_count:
                state_nxt = pix_last ? hist_pkg::acq_count : hist_pkg::input_count;
            hist_pkg::acq_count:
                state_nxt = acq_last ? hist_pkg::reset_all : hist_pkg::input_count;
            default:
                state_nxt = hist_pkg::reset_all;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            his_num <= 1'b0;
        end else begin
            case (state)
                hist_pkg::input_count: begin
                    in_cnt <= in_last ? '0 : in_cnt + 1'b1;
                end
                hist_pkg::pixel_count: begin
                    pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
                end
                hist_pkg::acq_count: begin
                    acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
                    if (acq_last) begin
                        his_num <= ~his_num; // swap banks
                    end
                end
                default: begin // reset_all
                    in_cnt  <= '0;
                    pix_cnt <= '0;
                    acq_cnt <= '0;
                end
            endcase
        end
    end

    assign window   = (state == hist_pkg::input_count);
    assign acq_done = (state == hist_pkg::acq_count) && acq_last;

    // done only in acq_count with slot and pixel counters wrapped
    a_done_state: assert property (@(posedge clk) disable iff (!res)
        acq_done |-> (state == hist_pkg::acq_count) && (in_cnt == '0) && (pix_cnt == '0));

endmodule

// ==== event_decode.sv ====
`timescale 1ns/1ps

module event_decode #(
    parameter int TIME_W = 8,
    parameter int BIN_W  = 4
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 window,
    input  hist_pkg::ev_op_t     ev_op,
    input  logic [TIME_W-1:0]    ev_time,
    output logic                 hit,
    output logic [BIN_W-1:0]     hit_bin
);

    logic             accept;
    logic [BIN_W-1:0] bin;

    always_comb begin
        case (ev_op)
            hist_pkg::ev_fine: begin
                accept = window;
                bin    = ev_time[BIN_W-1:0];
            end
            hist_pkg::ev_coarse: begin
                accept = window;
                bin    = ev_time[TIME_W-1 -: BIN_W];
            end
            default: begin // idle and reserved codes
                accept = 1'b0;
                bin    = ev_time[BIN_W-1:0];
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit <= 1'b0;
        end else begin
            hit <= accept;
        end
    end

    always_ff @(posedge clk) begin
        hit_bin <= bin;
    end

endmodule

// ==== hist_accumulate.sv ====
`timescale 1ns/1ps

module hist_accumulate #(
    parameter int BIN_W = 4,
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             res,
    input  logic             his_num,
    input  logic             hit,
    input  logic [BIN_W-1:0] hit_bin,
    input  logic             acq_done,
    input  logic             rd_en,
    input  logic [BIN_W-1:0] rd_addr,
    output logic [CNT_W-1:0] rd_data
);

    localparam int NBINS = 2 ** BIN_W;

    logic [CNT_W-1:0] bank [2][NBINS];

    logic             idle;
    logic [CNT_W-1:0] cur;
    logic [CNT_W-1:0] cnt_inc;

    assign idle = ~his_num;

    // read side of the update, active bank only
    assign cur     = bank[his_num][hit_bin];
    assign cnt_inc = (cur == '1) ? cur : cur + 1'b1; // saturate at all ones

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < NBINS; i++) begin
                    bank[b][i] <= '0;
                end
            end
            rd_data <= '0;
        end else begin
            if (hit) begin
                bank[his_num][hit_bin] <= cnt_inc; // lands before the next hit reads
            end
            if (rd_en) begin
                rd_data             <= bank[idle][rd_addr];
                bank[idle][rd_addr] <= '0; // clear on read
            end
        end
    end

    // decode pipe must be empty by the time the banks swap
    a_drained: assert property (@(posedge clk) disable iff (!res)
        acq_done |-> !hit);

endmodule

// ==== hist_readout.sv ====
`timescale 1ns/1ps

module hist_readout #(
    parameter int BIN_W = 4,
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             res,
    input  logic             acq_done,
    output logic             rd_en,
    output logic [BIN_W-1:0] rd_addr,
    input  logic [CNT_W-1:0] rd_data,
    output logic             rd_valid,
    output logic [BIN_W-1:0] rd_bin,
    output logic [CNT_W-1:0] rd_count
);

    logic             active;
    logic [BIN_W-1:0] addr;
    logic             valid_q;
    logic [BIN_W-1:0] bin_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active  <= 1'b0;
            addr    <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= active; // read latency is one cycle
            if (acq_done) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (active) begin
                addr <= addr + 1'b1;
                if (addr == '1) begin
                    active <= 1'b0; // last bin issued
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        bin_q <= addr;
    end

    assign rd_en    = active;
    assign rd_addr  = addr;
    assign rd_valid = valid_q;
    assign rd_bin   = bin_q;
    assign rd_count = rd_data;

    // histogram period too short for a full sweep
    a_sweep_done: assert property (@(posedge clk) disable iff (!res)
        acq_done |-> !active && !valid_q);

endmodule

// ==== hist_top.sv ====
`timescale 1ns/1ps

module hist_top #(
    parameter int TIME_W           = 8,
    parameter int BIN_W            = 4,
    parameter int CNT_W            = 16,
    parameter int INPUTS_PER_PIXEL = 2,
    parameter int PIXELS_PER_ACQ   = 200,
    parameter int ACQ_PER_HIST     = 33333
) (
    input  logic                 clk,
    input  logic                 res,
    input  hist_pkg::ev_op_t     ev_op,
    input  logic [TIME_W-1:0]    ev_time,
    output logic                 window,
    output logic                 his_num,
    output logic                 acq_done,
    output logic                 rd_valid,
    output logic [BIN_W-1:0]     rd_bin,
    output logic [CNT_W-1:0]     rd_count
);

    logic             hit;
    logic [BIN_W-1:0] hit_bin;
    logic             rd_en;
    logic [BIN_W-1:0] rd_addr;
    logic [CNT_W-1:0] rd_data;

    hist_sequencer #(
        .INPUTS_PER_PIXEL (INPUTS_PER_PIXEL),
        .PIXELS_PER_ACQ   (PIXELS_PER_ACQ),
        .ACQ_PER_HIST     (ACQ_PER_HIST)
    ) seq0 (
        .clk      (clk),
        .res      (res),
        .window   (window),
        .acq_done (acq_done),
        .his_num  (his_num)
    );

    event_decode #(.TIME_W(TIME_W), .BIN_W(BIN_W)) dec0 (
        .clk     (clk),
        .res     (res),
        .window  (window),
        .ev_op   (ev_op),
        .ev_time (ev_time),
        .hit     (hit),
        .hit_bin (hit_bin)
    );

    hist_accumulate #(.BIN_W(BIN_W), .CNT_W(CNT_W)) acc0 (
        .clk      (clk),
        .res      (res),
        .his_num  (his_num),
        .hit      (hit),
        .hit_bin  (hit_bin),
        .acq_done (acq_done),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    hist_readout #(.BIN_W(BIN_W), .CNT_W(CNT_W)) rdo0 (
        .clk      (clk),
        .res      (res),
        .acq_done (acq_done),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_bin   (rd_bin),
        .rd_count (rd_count)
    );

endmodule

// ==== tb_hist_top.sv ====
`timescale 1ns/1ps

module tb_hist_top;

    localparam int TIME_W    = 6;
    localparam int BIN_W     = 3;
    localparam int CNT_W     = 4;
    localparam int IN_PIX    = 4;
    localparam int PIX_ACQ   = 3;
    localparam int ACQ_HIST  = 2;
    localparam int NBINS     = 2 ** BIN_W;
    localparam int MAX_CNT   = 2 ** CNT_W - 1;
    localparam int SLOT_SPAN = PIX_ACQ * (IN_PIX + 1) + 1; // one acquisition
    localparam int PERIOD    = 1 + ACQ_HIST * SLOT_SPAN;
    localparam int NUM_TESTS = 5;
    localparam int RESET_CYC = 5;
    localparam int TAIL_CYC  = 12;
    localparam int CLK_NS    = 4;
    localparam int RUN_CYC   = RESET_CYC + NUM_TESTS * PERIOD + TAIL_CYC;
    localparam logic [BIN_W-1:0] SAT_BIN = 3'd5;

    logic               clk;
    logic               res;
    hist_pkg::ev_op_t   ev_op;
    logic [TIME_W-1:0]  ev_time;
    logic               window;
    logic               his_num;
    logic               acq_done;
    logic               rd_valid;
    logic [BIN_W-1:0]   rd_bin;
    logic [CNT_W-1:0]   rd_count;

    // reference model state
    int               pos;
    int               since;
    int               dones;
    int               beats;
    logic             exp_his;
    logic             exp_valid;
    logic [BIN_W-1:0] mbin;
    int               model [NBINS];
    int               saved [NBINS];
    string            saved_name;

    hist_top #(
        .TIME_W           (TIME_W),
        .BIN_W            (BIN_W),
        .CNT_W            (CNT_W),
        .INPUTS_PER_PIXEL (IN_PIX),
        .PIXELS_PER_ACQ   (PIX_ACQ),
        .ACQ_PER_HIST     (ACQ_HIST)
    ) dut0 (
        .clk      (clk),
        .res      (res),
        .ev_op    (ev_op),
        .ev_time  (ev_time),
        .window   (window),
        .his_num  (his_num),
        .acq_done (acq_done),
        .rd_valid (rd_valid),
        .rd_bin   (rd_bin),
        .rd_count (rd_count)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "random_mix";
            1:       return "pixel_burst";
            2:       return "saturate";
            3:       return "ignored_codes";
            4:       return "random_tail";
            default: return "idle";
        endcase
    endfunction

    // slot position inside a period, 0 is the reset_all cycle
    function automatic logic window_at(input int p);
        int q;
        if (p < 1 || p >= PERIOD) return 1'b0;
        q = (p - 1) % SLOT_SPAN;
        if (q == SLOT_SPAN - 1) return 1'b0; // acq_count
        return (q % (IN_PIX + 1)) < IN_PIX;
    endfunction

    function automatic int pixel_at(input int p);
        int q;
        q = (p - 1) % SLOT_SPAN;
        return ((p - 1) / SLOT_SPAN) * PIX_ACQ + q / (IN_PIX + 1);
    endfunction

    function automatic logic counts(input hist_pkg::ev_op_t op);
        return (op == hist_pkg::ev_fine) || (op == hist_pkg::ev_coarse);
    endfunction

    function automatic logic [BIN_W-1:0] bin_of(input hist_pkg::ev_op_t op,
                                                input logic [TIME_W-1:0] t);
        if (op == hist_pkg::ev_coarse) return t[TIME_W-1 -: BIN_W];
        return t[BIN_W-1:0];
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // drives the inputs seen during slot c of the current period
    task automatic drive_slot(input int test, input int c);
        logic [31:0]      rnd;
        logic [BIN_W-1:0] b;
        logic             in_win;
        rnd    = $urandom;
        in_win = window_at(c);
        b      = BIN_W'(pixel_at(c));
        case (test)
            1: begin
                if (in_win && (pixel_at(c) % 2 == 0)) begin
                    ev_op   <= hist_pkg::ev_fine;
                    ev_time <= {rnd[TIME_W-BIN_W-1:0], b};
                end else if (in_win) begin
                    ev_op   <= hist_pkg::ev_coarse;
                    ev_time <= {b, rnd[TIME_W-BIN_W-1:0]};
                end else begin
                    ev_op   <= hist_pkg::ev_op_t'(rnd[9:8]);
                    ev_time <= rnd[TIME_W-1:0];
                end
            end
            2: begin // every slot at one bin, outside ones dropped
                ev_op   <= hist_pkg::ev_fine;
                ev_time <= {rnd[TIME_W-BIN_W-1:0], SAT_BIN};
            end
            3: begin
                ev_op   <= in_win ? (rnd[8] ? hist_pkg::ev_resv : hist_pkg::ev_idle)
                                  : (rnd[8] ? hist_pkg::ev_coarse : hist_pkg::ev_fine);
                ev_time <= rnd[TIME_W-1:0];
            end
            default: begin
                ev_op   <= hist_pkg::ev_op_t'(rnd[9:8]);
                ev_time <= rnd[TIME_W-1:0];
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (!res) begin
            pos = 0;
        end else begin
            assert (window == window_at(pos)) else stop_run($sformatf(
                "mismatch %s: window at slot %0d expected %0b actual %0b",
                test_name(dones), pos, window_at(pos), window));
            assert (acq_done == (pos == PERIOD - 1)) else stop_run($sformatf(
                "mismatch %s: acq_done at slot %0d expected %0b actual %0b",
                test_name(dones), pos, (pos == PERIOD - 1), acq_done));
            assert (his_num == exp_his) else stop_run($sformatf(
                "mismatch %s: his_num expected %0b actual %0b",
                test_name(dones), exp_his, his_num));
            exp_valid = (since >= 2) && (since < 2 + NBINS);
            assert (rd_valid == exp_valid) else stop_run($sformatf(
                "mismatch %s: rd_valid %0d cycles after acq_done expected %0b actual %0b",
                saved_name, since, exp_valid, rd_valid));
            if (exp_valid) begin
                assert (int'(rd_bin) == since - 2) else stop_run($sformatf(
                    "mismatch %s: rd_bin expected %0d actual %0d",
                    saved_name, since - 2, rd_bin));
                assert (int'(rd_count) == saved[since-2]) else stop_run($sformatf(
                    "mismatch %s: bin %0d count expected %0d actual %0d",
                    saved_name, since - 2, saved[since-2], rd_count));
                beats++;
            end
            if (window_at(pos) && counts(ev_op)) begin
                mbin = bin_of(ev_op, ev_time);
                if (model[mbin] < MAX_CNT) model[mbin]++;
            end
            if (acq_done) begin
                saved      = model;
                saved_name = test_name(dones);
                for (int i = 0; i < NBINS; i++) model[i] = 0;
                dones++;
                exp_his = ~exp_his; // bank swap
                since   = 1;
            end else if (since > 0) begin
                since++;
            end
            pos = (pos + 1) % PERIOD;
        end
    end

    // watchdog, twice the whole run
    initial begin
        #(2 * RUN_CYC * CLK_NS);
        $display("timeout: run did not finish within %0d cycles", 2 * RUN_CYC);
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        clk        = 1'b0;
        res        = 1'b0;
        ev_op      = hist_pkg::ev_idle;
        ev_time    = '0;
        pos        = 0;
        since      = 0;
        dones      = 0;
        beats      = 0;
        exp_his    = 1'b0;
        saved_name = "none";
        for (int i = 0; i < NBINS; i++) begin
            model[i] = 0;
            saved[i] = 0;
        end
        void'($urandom(32'ha1d9_9fad));
        repeat (RESET_CYC) @(posedge clk);
        res <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int c = 0; c < PERIOD; c++) begin
                drive_slot(t, c);
                @(posedge clk);
            end
        end
        ev_op   <= hist_pkg::ev_idle;
        ev_time <= '0;
        repeat (TAIL_CYC) @(posedge clk); // last readout drains
        #1;
        if (dones == NUM_TESTS && beats == NUM_TESTS * NBINS) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("run incomplete: %0d histograms and %0d readout beats seen",
                     dones, beats);
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

// ==== hist_core.f ====
hist_pkg.sv
hist_sequencer.sv
event_decode.sv
hist_accumulate.sv
hist_readout.sv
hist_top.sv
tb_hist_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f hist_core.f \
    --top-module tb_hist_top \
    -o sim_hist

./obj_dir/sim_hist
